// File: design/vga_config.svh
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

`default_nettype none

// 640x480 at 60 Hz, horizontal values in pixels
`define VGA_H_DISP 640
`define VGA_H_FP 16
`define VGA_H_PW 96
`define VGA_H_BP 48

// vertical values in lines
`define VGA_V_DISP 480
`define VGA_V_FP 10
`define VGA_V_PW 2
`define VGA_V_BP 33

`define VGA_H_PV 1'b0 // negative hsync
`define VGA_V_PV 1'b0 // negative vsync

`define VGA_H_W 10 // holds 0..799
`define VGA_V_W 10 // holds 0..524

`define VGA_FIFO_DEPTH 16 // power of two
`define VGA_CREDIT_W 5 // holds 0..depth

`default_nettype wire

`endif

// File: design/vga_pkg.sv
`include "vga_config.svh"

`default_nettype none

package vga_pkg;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef struct packed {
		logic valid; // beat strobe, one credit each
		logic sof; // first pixel of a frame
		rgb565_t pixel;
	} pix_in_t;

	typedef struct packed {
		logic sof;
		rgb565_t pixel;
	} pix_entry_t; // fifo word

	typedef struct packed {
		logic h_sync;
		logic v_sync;
		logic h_en;
		logic v_en;
		logic frame_start; // first active position of frame
		logic [`VGA_H_W-1:0] h_count;
		logic [`VGA_V_W-1:0] v_count;
	} vga_timing_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
		logic h_sync;
		logic v_sync;
	} vga_out_t;

	typedef struct packed {
		logic underrun; // sticky
		logic sof_err; // sticky
	} vga_status_t;

endpackage

`default_nettype wire

// File: design/pixel_ingress.sv
`include "vga_config.svh"

`default_nettype none

module pixel_ingress (
	input logic vga_clk,
	input logic rst,
	input vga_pkg::pix_in_t pix_in, // from renderer, credit governed
	input logic pop, // from output side
	output vga_pkg::pix_entry_t head, // oldest entry
	output logic head_valid,
	output logic credit // one pulse per freed entry
);

	localparam int DEPTH = `VGA_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [`VGA_CREDIT_W-1:0] FULL_COUNT = `VGA_CREDIT_W'(DEPTH);

	vga_pkg::pix_entry_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [`VGA_CREDIT_W-1:0] count; // occupancy
	logic push;
	logic full;

	assign push = pix_in.valid;
	assign full = (count == FULL_COUNT);

	// storage, written at the tail
	always_ff @(posedge vga_clk) begin
		if (push) begin
			mem[wr_ptr] <= '{sof: pix_in.sof, pixel: pix_in.pixel};
		end
	end

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or push and pop together
			endcase
			credit <= pop; // entry freed, hand credit back
		end
	end

	assign head = mem[rd_ptr];
	assign head_valid = (count != '0);

	// upstream must hold a credit for every beat
	a_no_overflow: assert property (
		@(posedge vga_clk) disable iff (rst)
		push |-> !full
	) else $error("pixel pushed into a full FIFO");

	// output side only pops a presented head
	a_no_underflow: assert property (
		@(posedge vga_clk) disable iff (rst)
		pop |-> head_valid
	) else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// File: design/vga_sync_gen.sv
`include "vga_config.svh"

`default_nettype none

module vga_sync_gen (
	input logic vga_clk,
	input logic rst,
	output vga_pkg::vga_timing_t timing
);

	localparam int H_TOTAL = `VGA_H_DISP + `VGA_H_FP + `VGA_H_PW + `VGA_H_BP;

	// horizontal turning points
	localparam logic [`VGA_H_W-1:0] H_SYNC_START = `VGA_H_W'(`VGA_H_DISP + `VGA_H_FP - 1);
	localparam logic [`VGA_H_W-1:0] H_SYNC_END =
		`VGA_H_W'(`VGA_H_DISP + `VGA_H_FP + `VGA_H_PW - 1);
	localparam logic [`VGA_H_W-1:0] H_DISP_START = `VGA_H_W'(H_TOTAL - 1);
	localparam logic [`VGA_H_W-1:0] H_DISP_END = `VGA_H_W'(`VGA_H_DISP - 1);

	// vertical turning points, in lines
	localparam logic [`VGA_V_W-1:0] V_SYNC_START = `VGA_V_W'(`VGA_V_DISP + `VGA_V_FP - 1);
	localparam logic [`VGA_V_W-1:0] V_SYNC_END =
		`VGA_V_W'(`VGA_V_DISP + `VGA_V_FP + `VGA_V_PW - 1);
	localparam logic [`VGA_V_W-1:0] V_DISP_START =
		`VGA_V_W'(`VGA_V_DISP + `VGA_V_FP + `VGA_V_PW + `VGA_V_BP - 1);
	localparam logic [`VGA_V_W-1:0] V_DISP_END = `VGA_V_W'(`VGA_V_DISP - 1);

	localparam logic H_PV = `VGA_H_PV;
	localparam logic V_PV = `VGA_V_PV;

	logic [`VGA_H_W-1:0] h_count;
	logic [`VGA_V_W-1:0] v_count;
	logic h_sync;
	logic v_sync;
	logic h_en;
	logic v_en;

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			h_count <= H_SYNC_START; // next edge opens the hsync pulse
			v_count <= V_SYNC_START;
			h_sync <= ~H_PV;
			v_sync <= ~V_PV;
			h_en <= 1'b0;
			v_en <= 1'b0;
		end else begin
			if (h_count == H_SYNC_END) begin
				h_count <= h_count + 1'b1;
				h_sync <= ~H_PV; // pulse over
			end else if (h_count == H_DISP_START) begin
				h_count <= '0; // wrap into active area
				h_en <= 1'b1;
			end else if (h_count == H_DISP_END) begin
				h_count <= h_count + 1'b1;
				h_en <= 1'b0;
			end else if (h_count == H_SYNC_START) begin
				h_count <= h_count + 1'b1;
				h_sync <= H_PV;
				// vertical steps once per line, at hsync start
				if (v_count == V_SYNC_END) begin
					v_count <= v_count + 1'b1;
					v_sync <= ~V_PV;
				end else if (v_count == V_DISP_START) begin
					v_count <= '0;
					v_en <= 1'b1;
				end else if (v_count == V_DISP_END) begin
					v_count <= v_count + 1'b1;
					v_en <= 1'b0;
				end else if (v_count == V_SYNC_START) begin
					v_count <= v_count + 1'b1;
					v_sync <= V_PV;
				end else begin
					v_count <= v_count + 1'b1;
				end
			end else begin
				h_count <= h_count + 1'b1;
			end
		end
	end

	assign timing.h_sync = h_sync;
	assign timing.v_sync = v_sync;
	assign timing.h_en = h_en;
	assign timing.v_en = v_en;
	assign timing.frame_start = h_en & v_en & (h_count == '0) & (v_count == '0);
	assign timing.h_count = h_count;
	assign timing.v_count = v_count;

	a_h_range: assert property (
		@(posedge vga_clk) disable iff (rst)
		h_count < `VGA_H_W'(H_TOTAL)
	) else $error("h_count left the 800 cycle line");

endmodule

`default_nettype wire

// File: design/vga_pixel_out.sv
`include "vga_config.svh"

`default_nettype none

module vga_pixel_out (
	input logic vga_clk,
	input logic rst,
	input vga_pkg::vga_timing_t timing,
	input vga_pkg::pix_entry_t head,
	input logic head_valid,
	output logic pop,
	output vga_pkg::vga_out_t vga, // to DAC, one cycle behind timing
	output vga_pkg::vga_status_t status
);

	logic active;
	logic [3:0] r_next;
	logic [3:0] g_next;
	logic [3:0] b_next;

	assign active = timing.h_en & timing.v_en;
	assign pop = active & head_valid; // empty FIFO means no pop

	// 565 down to 444 and black when nothing is popped
	always_comb begin
		if (pop) begin
			r_next = head.pixel.r[4:1];
			g_next = head.pixel.g[5:2];
			b_next = head.pixel.b[4:1];
		end else begin
			r_next = 4'h0;
			g_next = 4'h0;
			b_next = 4'h0;
		end
	end

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			vga.r <= 4'h0;
			vga.g <= 4'h0;
			vga.b <= 4'h0;
			vga.h_sync <= ~`VGA_H_PV; // idle level
			vga.v_sync <= ~`VGA_V_PV;
			status <= '0;
		end else begin
			vga.r <= r_next;
			vga.g <= g_next;
			vga.b <= b_next;
			vga.h_sync <= timing.h_sync; // keeps syncs aligned with colour
			vga.v_sync <= timing.v_sync;
			status.underrun <= status.underrun | (active & ~head_valid);
			// sof flag must line up with the frame start position
			status.sof_err <= status.sof_err | (pop & (head.sof ^ timing.frame_start));
		end
	end

endmodule

`default_nettype wire

// File: design/vga_top.sv
`include "vga_config.svh"

`default_nettype none

module vga_top (
	input logic vga_clk,
	input logic rst,
	input vga_pkg::pix_in_t pix_in,
	output logic credit,
	output vga_pkg::vga_out_t vga,
	output vga_pkg::vga_status_t status
);

	vga_pkg::pix_entry_t head;
	logic head_valid;
	logic pop;
	vga_pkg::vga_timing_t timing;

	pixel_ingress i_pixel_ingress (
		.vga_clk (vga_clk),
		.rst (rst),
		.pix_in (pix_in),
		.pop (pop),
		.head (head),
		.head_valid (head_valid),
		.credit (credit)
	);

	vga_sync_gen i_vga_sync_gen (
		.vga_clk (vga_clk),
		.rst (rst),
		.timing (timing)
	);

	vga_pixel_out i_vga_pixel_out (
		.vga_clk (vga_clk),
		.rst (rst),
		.timing (timing),
		.head (head),
		.head_valid (head_valid),
		.pop (pop),
		.vga (vga),
		.status (status)
	);

endmodule

`default_nettype wire

// File: tb/tb_vga_top.sv
`include "vga_config.svh"

`default_nettype none

module tb_vga_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = `VGA_FIFO_DEPTH;
	localparam int FRAME_PIX = `VGA_H_DISP * `VGA_V_DISP;
	localparam int H_TOTAL = `VGA_H_DISP + `VGA_H_FP + `VGA_H_PW + `VGA_H_BP;
	localparam int V_TOTAL = `VGA_V_DISP + `VGA_V_FP + `VGA_V_PW + `VGA_V_BP;
	localparam int H_ACT_START = `VGA_H_PW + `VGA_H_BP; // cycles after hsync fall
	localparam int H_ACT_END = H_ACT_START + `VGA_H_DISP;
	localparam int V_ACT_START = `VGA_V_PW + `VGA_V_BP; // lines after vsync fall
	localparam int V_ACT_END = V_ACT_START + `VGA_V_DISP;

	logic vga_clk;
	logic rst;
	vga_pkg::pix_in_t pix_in;
	logic credit;
	vga_pkg::vga_out_t vga;
	vga_pkg::vga_status_t status;

	logic [31:0] lfsr;
	logic [11:0] expected_q[$]; // 444 colours still to appear
	logic [11:0] pend_colour; // driven but not yet in the FIFO
	logic pend_valid;
	int credits;
	int sent;
	int returned;
	int popped;
	int errors;
	int h_since_fall;
	int lines_since_vfall;
	bit timed_out;
	bit feeding;
	bit sof_first;
	logic prev_hs;
	logic prev_vs;
	bit hfall;
	bit vfall;

	vga_top i_vga_top (
		.vga_clk (vga_clk),
		.rst (rst),
		.pix_in (pix_in),
		.credit (credit),
		.vga (vga),
		.status (status)
	);

	initial begin
		vga_clk = 1'b0;
		forever #50 vga_clk = ~vga_clk;
	end

	// fibonacci lfsr with taps 32 22 2 1 stepped once per bit
	function automatic logic [15:0] random_pixel();
		logic [15:0] val;
		logic fb;
		int i;
		val = '0;
		for (i = 0; i < 16; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		timed_out = 1'b1;
		$display("timeout at %0t while waiting for %s", $time, what);
	endtask

	// per cycle track position, check colour, count credits and drive a beat
	task automatic tick();
		logic [11:0] exp_colour;
		bit active;
		@(negedge vga_clk);
		hfall = prev_hs && !vga.h_sync;
		vfall = prev_vs && !vga.v_sync;
		prev_hs = vga.h_sync;
		prev_vs = vga.v_sync;
		if (hfall) begin
			h_since_fall = 0;
			lines_since_vfall = vfall ? 0 : lines_since_vfall + 1;
		end else begin
			h_since_fall++;
		end
		active = (h_since_fall >= H_ACT_START) && (h_since_fall < H_ACT_END) &&
			(lines_since_vfall >= V_ACT_START) && (lines_since_vfall < V_ACT_END);
		exp_colour = 12'h000; // blanking and underrun are black
		if (active && expected_q.size() > 0) begin
			exp_colour = expected_q.pop_front();
			popped++;
		end
		check_value("colour", 32'({vga.r, vga.g, vga.b}), 32'(exp_colour));
		if (credit) begin
			credits++;
			returned++;
		end
		if (pend_valid) begin
			expected_q.push_back(pend_colour); // pushed at the last rising edge
		end
		pend_valid = 1'b0;
		pix_in = '0;
		if (feeding && credits > 0) begin
			pix_in.valid = 1'b1;
			pix_in.sof = (sent % FRAME_PIX == 0) && (sent != 0 || sof_first);
			pix_in.pixel = random_pixel();
			pend_colour = {pix_in.pixel.r[4:1], pix_in.pixel.g[5:2], pix_in.pixel.b[4:1]};
			pend_valid = 1'b1;
			credits--;
			sent++;
		end
	endtask

	task automatic reset_and_check(input bit with_sof);
		rst = 1'b1;
		feeding = 1'b0;
		sof_first = with_sof;
		expected_q.delete();
		pend_valid = 1'b0;
		credits = DEPTH; // upstream starts full of credits
		sent = 0;
		returned = 0;
		popped = 0;
		prev_hs = 1'b1;
		prev_vs = 1'b1;
		h_since_fall = 0;
		lines_since_vfall = V_TOTAL; // outside the display until the first vsync
		repeat (16) begin
			tick();
			check_value("h_sync in reset", 32'(vga.h_sync), 32'd1);
			check_value("v_sync in reset", 32'(vga.v_sync), 32'd1);
			check_value("credit in reset", 32'(credit), 32'd0);
			check_value("status in reset", 32'(status), 32'd0);
		end
		rst = 1'b0;
		feeding = 1'b1;
	endtask

	task automatic horizontal_test();
		int n;
		int period;
		int low;
		int start_ret;
		n = 0;
		while (popped == 0 && n < 40000) begin
			tick();
			n++;
		end
		if (popped == 0) begin
			report_timeout("the first active pixel");
			return;
		end
		n = 0;
		while (!hfall && n < 2 * H_TOTAL) begin
			tick();
			n++;
		end
		if (!hfall) begin
			report_timeout("an hsync falling edge in the display area");
			return;
		end
		period = 0;
		low = 1;
		start_ret = returned;
		while (period < 2 * H_TOTAL) begin
			tick();
			period++;
			if (hfall) begin
				break;
			end
			if (!vga.h_sync) begin
				low++;
			end
		end
		check_value("hsync period", 32'(period), 32'(H_TOTAL));
		check_value("hsync low cycles", 32'(low), 32'(`VGA_H_PW));
		check_value("pixels in one line", 32'(returned - start_ret), 32'(`VGA_H_DISP));
	endtask

	task automatic pixel_path_test();
		int n;
		n = 0;
		while (popped < FRAME_PIX && n < V_TOTAL * H_TOTAL) begin
			tick();
			n++;
		end
		if (popped < FRAME_PIX) begin
			report_timeout("the first full frame of pixels");
			return;
		end
		check_value("sof_err after a frame", 32'(status.sof_err), 32'd0);
		check_value("underrun after a frame", 32'(status.underrun), 32'd0);
	endtask

	task automatic vertical_test();
		int n;
		int period;
		int low;
		n = 0;
		while (!vfall && n < V_TOTAL * H_TOTAL) begin
			tick();
			n++;
		end
		if (!vfall) begin
			report_timeout("a vsync falling edge");
			return;
		end
		period = 0;
		low = 1;
		while (period < 2 * V_TOTAL * H_TOTAL) begin
			tick();
			period++;
			if (vfall) begin
				break;
			end
			if (!vga.v_sync) begin
				low++;
			end
		end
		check_value("vsync period", 32'(period), 32'(V_TOTAL * H_TOTAL));
		check_value("vsync low cycles", 32'(low), 32'(`VGA_V_PW * H_TOTAL));
	endtask

	task automatic underrun_test();
		int n;
		int start_ret;
		n = 0;
		start_ret = returned;
		while (returned == start_ret && n < 40000) begin
			tick();
			n++;
		end
		if (returned == start_ret) begin
			report_timeout("a returned credit in the display area");
			return;
		end
		repeat (`VGA_H_DISP / 2) tick(); // mid-line
		feeding = 1'b0;
		n = 0;
		while ((expected_q.size() > 0 || pend_valid) && n < 200) begin
			tick();
			n++;
		end
		if (expected_q.size() > 0 || pend_valid) begin
			report_timeout("the FIFO to drain");
			return;
		end
		repeat (2) tick();
		check_value("underrun after drain", 32'(status.underrun), 32'd1);
		check_value("credits returned", 32'(returned), 32'(sent));
		repeat (2000) tick(); // black output checked every cycle
		check_value("underrun stays set", 32'(status.underrun), 32'd1);
	endtask

	task automatic misalignment_test();
		int n;
		reset_and_check(1'b0);
		n = 0;
		while (popped == 0 && n < 40000) begin
			tick();
			n++;
		end
		if (popped == 0) begin
			report_timeout("the first pixel of the frame");
			return;
		end
		repeat (2) tick();
		check_value("sof_err without sof", 32'(status.sof_err), 32'd1);
	endtask

	initial begin
		rst = 1'b1;
		pix_in = '0;
		lfsr = 32'd84706;
		errors = 0;
		timed_out = 1'b0;
		reset_and_check(1'b1);
		horizontal_test();
		if (!timed_out) pixel_path_test();
		if (!timed_out) vertical_test();
		if (!timed_out) underrun_test();
		if (!timed_out) misalignment_test();
		$display("errors: %0d, timeouts: %0d", errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/vga_pkg.sv
design/pixel_ingress.sv
design/vga_sync_gen.sv
design/vga_pixel_out.sv
design/vga_top.sv
tb/tb_vga_top.sv

// File: Makefile
SIM = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP = tb_vga_top
FILELIST = filelist.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = All checks passed

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
